// ==== logic/vic_map_pkg.sv ====
// VIC-20 memory map
// Load limits, the kernal ROM window, the BASIC pointer table and the
// cartridge block mask used by the program loader
`default_nettype none

package vic_map_pkg;

	////////////////////
	// Load limits
	////////////////////

	// PRG data never goes past the BASIC RAM area
	localparam logic [15:0] prg_limit_c = 16'hA000;

	// Cartridge images stop below the I/O and ROM area
	localparam logic [15:0] cart_limit_c = 16'hC000;

	////////////////////
	// Kernal ROM window
	////////////////////

	// File offsets inside this window end up in the kernal area
	localparam logic [15:0] rom_lo_c = 16'h4000;
	localparam logic [15:0] rom_hi_c = 16'h8000;
	localparam logic [15:0] rom_shift_c = 16'h8000;

	////////////////////
	// BASIC pointers
	////////////////////

	// Start of variables, arrays, end of arrays and end of program
	// Even entries get the low byte, odd entries the high byte
	localparam int unsigned ptr_count_c = 8;
	localparam logic [15:0] ptr_table_c [ptr_count_c] = '{
		16'h002D, 16'h002E,
		16'h002F, 16'h0030,
		16'h0031, 16'h0032,
		16'h00AE, 16'h00AF
	};

	////////////////////
	// Cartridge blocks
	////////////////////

	// Bits 0 to 3 are blocks 0 to 3, bit 4 is block 5
	localparam int unsigned cart_blk_w = 5;
	typedef logic [cart_blk_w-1:0] cart_blk_t;

endpackage

`default_nettype wire

// ==== logic/loader_pkg.sv ====
// Loader stream definitions
// File kinds, the host index codes and the records that move between
// the stages of the download pipeline
`default_nettype none

package loader_pkg;

	////////////////////
	// File kinds
	////////////////////

	typedef enum logic [2:0] {
		NONE,
		PRG,
		ROM,
		CRT,
		CT
	} file_kind_e;

	// Index codes sent by the host with each file
	localparam logic [7:0] prg_index_c = 8'h01;
	localparam logic [7:0] rom_index_c = 8'h06;
	localparam logic [7:0] crt_index_c = 8'h41;
	localparam logic [7:0] ct_index_c = 8'h81;

	////////////////////
	// Stage records
	////////////////////

	// One registered host byte plus download framing
	typedef struct packed {
		logic        valid;
		logic [24:0] offset;
		logic [7:0]  data;
		file_kind_e  kind;
		logic        dl_start;
		logic        dl_end;
		logic [7:0]  ext;
	} host_beat_t;

	// Write strobe to the memory configuration port
	typedef struct packed {
		logic        valid;
		logic [15:0] addr;
		logic [7:0]  data;
	} mem_write_t;

	// Start flag lets later stages abort or restart per download
	typedef struct packed {
		mem_write_t  wr;
		file_kind_e  kind;
		logic        dl_start;
		logic        dl_end;
		logic [15:0] final_addr;
	} addr_beat_t;

endpackage

`default_nettype wire

// ==== logic/download_classifier.sv ====
// Download classifier
// Registers the host byte stream, decodes the file kind from the index
// code and marks the first and last beat of each download
`timescale 1ns/1ps
`default_nettype none

module download_classifier (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    dl_active_i,
	input  wire [7:0]              dl_index_i,
	input  wire                    dl_wr_i,
	input  wire [24:0]             dl_addr_i,
	input  wire [7:0]              dl_data_i,
	input  wire [7:0]              dl_ext_i,
	output loader_pkg::host_beat_t beat_o
);
	import loader_pkg::*;

	logic       active_q;
	logic       start_edge;
	logic       end_edge;
	file_kind_e kind_dec;
	file_kind_e kind_q;
	file_kind_e kind_cur;

	assign start_edge = dl_active_i & ~active_q;
	assign end_edge = ~dl_active_i & active_q;

	// Index code to file kind
	always_comb begin
		case (dl_index_i)
			prg_index_c: kind_dec = PRG;
			rom_index_c: kind_dec = ROM;
			crt_index_c: kind_dec = CRT;
			ct_index_c:  kind_dec = CT;
			default:     kind_dec = NONE;
		endcase
	end

	// The start beat sees the fresh decode, later beats the latched kind
	assign kind_cur = start_edge ? kind_dec : kind_q;

	////////////////////
	// Framing
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q <= 1'b0;
			kind_q <= NONE;
		end else begin
			active_q <= dl_active_i;
			if (start_edge) begin
				kind_q <= kind_dec;
			end
		end
	end

	////////////////////
	// Output beat
	////////////////////

	always_ff @(posedge clk_sys) begin
		beat_o.offset <= dl_addr_i;
		beat_o.data <= dl_data_i;
		beat_o.ext <= dl_ext_i;
		beat_o.kind <= kind_cur;
		if (reset) begin
			beat_o.valid <= 1'b0;
			beat_o.dl_start <= 1'b0;
			beat_o.dl_end <= 1'b0;
		end else begin
			// Strobes outside a download are ignored
			beat_o.valid <= dl_wr_i & dl_active_i;
			beat_o.dl_start <= start_edge;
			beat_o.dl_end <= end_edge;
		end
	end

endmodule

`default_nettype wire

// ==== logic/load_address_gen.sv ====
// Load address generator
// Captures the load address header, keeps the running write address
// and applies the address window of each file kind
// ROM bytes bypass the running address and land in the kernal area
`timescale 1ns/1ps
`default_nettype none

module load_address_gen #(
	parameter logic [15:0] PRG_LIMIT = vic_map_pkg::prg_limit_c,
	parameter logic [15:0] CART_LIMIT = vic_map_pkg::cart_limit_c
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire loader_pkg::host_beat_t beat_i,
	output loader_pkg::addr_beat_t wr_o
);
	import loader_pkg::*;
	import vic_map_pkg::*;

	logic [15:0] run_q;
	logic [15:0] run_d;
	logic [15:0] ct_base;
	logic        ct_base_ok;
	logic        has_header;
	logic        in_rom_win;
	logic [15:0] limit;
	addr_beat_t  wr_d;

	// PRG and CRT carry a two byte header, CT takes its base from the extension
	assign has_header = (beat_i.kind == PRG) || (beat_i.kind == CRT);
	assign limit = (beat_i.kind == PRG) ? PRG_LIMIT : CART_LIMIT;

	assign in_rom_win = (beat_i.offset >= {9'd0, rom_lo_c}) &&
		(beat_i.offset < {9'd0, rom_hi_c});

	////////////////////
	// CT base address
	////////////////////

	always_comb begin
		ct_base = 16'h0000;
		ct_base_ok = 1'b0;
		if (beat_i.ext >= "2" && beat_i.ext <= "9") begin
			ct_base = {beat_i.ext[3:0], 12'h000};
			ct_base_ok = 1'b1;
		end else if (beat_i.ext >= "A" && beat_i.ext <= "B") begin
			// A and B map to blocks A000 and B000
			ct_base = {beat_i.ext[3:0] + 4'd9, 12'h000};
			ct_base_ok = 1'b1;
		end
	end

	////////////////////
	// Address and window
	////////////////////

	always_comb begin
		run_d = run_q;
		wr_d = '0;
		wr_d.kind = beat_i.kind;
		wr_d.dl_start = beat_i.dl_start;
		wr_d.dl_end = beat_i.dl_end;
		wr_d.final_addr = run_q;
		wr_d.wr.data = beat_i.data;
		wr_d.wr.addr = run_q;

		if (beat_i.dl_start && beat_i.kind == CT && ct_base_ok) begin
			run_d = ct_base;
		end

		if (beat_i.valid) begin
			if (beat_i.kind == ROM) begin
				wr_d.wr.valid = in_rom_win;
				wr_d.wr.addr = beat_i.offset[15:0] + rom_shift_c;
			end else if (has_header && beat_i.offset == 25'd0) begin
				run_d[7:0] = beat_i.data;
			end else if (has_header && beat_i.offset == 25'd1) begin
				run_d[15:8] = beat_i.data;
			end else if (beat_i.kind != NONE && run_q < limit) begin
				wr_d.wr.valid = 1'b1;
				run_d = run_q + 16'd1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		wr_o <= wr_d;
		if (reset) begin
			run_q <= 16'h0000;
			wr_o.wr.valid <= 1'b0;
			wr_o.dl_start <= 1'b0;
			wr_o.dl_end <= 1'b0;
		end else begin
			run_q <= run_d;
		end
	end

endmodule

`default_nettype wire

// ==== logic/basic_pointer_patcher.sv ====
// BASIC pointer patcher
// Passes data writes to the memory port and, once a PRG download ends,
// writes the end address into the eight BASIC pointer bytes
`timescale 1ns/1ps
`default_nettype none

module basic_pointer_patcher (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire loader_pkg::addr_beat_t wr_i,
	output loader_pkg::mem_write_t mem_wr_o
);
	import loader_pkg::*;
	import vic_map_pkg::*;

	// Step 0 is idle, even steps 2 to 14 issue entries 1 to 7
	localparam logic [3:0] last_step_c = 4'd14;

	logic [3:0]  step_q;
	logic [15:0] end_q;
	logic [2:0]  entry;
	logic        prg_done;
	logic        ptr_slot;
	mem_write_t  out_d;

	assign prg_done = wr_i.dl_end && (wr_i.kind == PRG);
	assign entry = step_q[3:1];
	assign ptr_slot = (step_q != 4'd0) && !step_q[0] && !wr_i.dl_start;

	////////////////////
	// Write select
	////////////////////

	always_comb begin
		out_d = wr_i.wr;
		if (!wr_i.wr.valid) begin
			if (prg_done) begin
				// Entry 0 goes out right away with the fresh end address
				out_d.valid = 1'b1;
				out_d.addr = ptr_table_c[0];
				out_d.data = wr_i.final_addr[7:0];
			end else if (ptr_slot) begin
				out_d.valid = 1'b1;
				out_d.addr = ptr_table_c[entry];
				out_d.data = entry[0] ? end_q[15:8] : end_q[7:0];
			end
		end
	end

	////////////////////
	// Step counter
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			step_q <= 4'd0;
		end else if (wr_i.dl_start) begin
			// A new download drops any patch still in progress
			step_q <= 4'd0;
		end else if (prg_done) begin
			step_q <= 4'd1;
		end else if (step_q == last_step_c) begin
			step_q <= 4'd0;
		end else if (step_q != 4'd0) begin
			step_q <= step_q + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (prg_done) begin
			end_q <= wr_i.final_addr;
		end
	end

	always_ff @(posedge clk_sys) begin
		mem_wr_o <= out_d;
		if (reset) begin
			mem_wr_o.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/cart_block_tracker.sv ====
// Cartridge block tracker
// Marks the 8 KB blocks filled by a cartridge image, holds the machine
// in reset during a CRT load and builds the expansion RAM masks
`timescale 1ns/1ps
`default_nettype none

module cart_block_tracker (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire loader_pkg::addr_beat_t wr_i,
	input  wire                    detach_i,
	input  wire vic_map_pkg::cart_blk_t extram_cfg_i,
	input  wire                    cart_writable_i,
	output logic                   cart_reset_o,
	output vic_map_pkg::cart_blk_t ram_ext_o,
	output vic_map_pkg::cart_blk_t ram_ext_ro_o
);
	import loader_pkg::*;
	import vic_map_pkg::*;

	cart_blk_t  mask_q;
	cart_blk_t  hit;
	logic [2:0] blk;
	logic       cart_wr;

	assign blk = wr_i.wr.addr[15:13];
	assign cart_wr = wr_i.wr.valid && (wr_i.kind == CRT || wr_i.kind == CT);

	// Block 4 is I/O space and never tracked
	always_comb begin
		hit = '0;
		if (cart_wr) begin
			if (blk < 3'd4) begin
				hit[blk[1:0]] = 1'b1;
			end else if (blk == 3'd5) begin
				hit[4] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset || detach_i) begin
			mask_q <= '0;
			cart_reset_o <= 1'b0;
		end else begin
			mask_q <= mask_q | hit;
			if (wr_i.kind == CRT && wr_i.dl_start) begin
				cart_reset_o <= 1'b1;
			end else if (wr_i.kind == CRT && wr_i.dl_end) begin
				cart_reset_o <= 1'b0;
			end
		end
	end

	assign ram_ext_o = extram_cfg_i | mask_q;
	assign ram_ext_ro_o = cart_writable_i ? '0 : mask_q;

endmodule

`default_nettype wire

// ==== logic/vic_loader_top.sv ====
// VIC-20 program and cartridge loader
// Three stage pipeline from the host byte stream to the memory
// configuration port, with cartridge block tracking on the side
`timescale 1ns/1ps
`default_nettype none

module vic_loader_top #(
	parameter logic [15:0] PRG_LIMIT = vic_map_pkg::prg_limit_c,
	parameter logic [15:0] CART_LIMIT = vic_map_pkg::cart_limit_c
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    dl_active_i,
	input  wire [7:0]              dl_index_i,
	input  wire                    dl_wr_i,
	input  wire [24:0]             dl_addr_i,
	input  wire [7:0]              dl_data_i,
	input  wire [7:0]              dl_ext_i,
	input  wire                    detach_i,
	input  wire vic_map_pkg::cart_blk_t extram_cfg_i,
	input  wire                    cart_writable_i,
	output loader_pkg::mem_write_t mem_wr_o,
	output logic                   cart_reset_o,
	output vic_map_pkg::cart_blk_t ram_ext_o,
	output vic_map_pkg::cart_blk_t ram_ext_ro_o
);
	import loader_pkg::*;

	host_beat_t beat;
	addr_beat_t addr_wr;

	// Stage 1
	download_classifier i_classifier (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_ext_i    (dl_ext_i),
		.beat_o      (beat)
	);

	// Stage 2
	load_address_gen #(
		.PRG_LIMIT  (PRG_LIMIT),
		.CART_LIMIT (CART_LIMIT)
	) i_addr_gen (
		.clk_sys (clk_sys),
		.reset   (reset),
		.beat_i  (beat),
		.wr_o    (addr_wr)
	);

	// Stage 3
	basic_pointer_patcher i_patcher (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.wr_i     (addr_wr),
		.mem_wr_o (mem_wr_o)
	);

	cart_block_tracker i_blk_tracker (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.wr_i            (addr_wr),
		.detach_i        (detach_i),
		.extram_cfg_i    (extram_cfg_i),
		.cart_writable_i (cart_writable_i),
		.cart_reset_o    (cart_reset_o),
		.ram_ext_o       (ram_ext_o),
		.ram_ext_ro_o    (ram_ext_ro_o)
	);

endmodule

`default_nettype wire

// ==== bench/vic_loader_assert.sv ====
// Memory port assertions for the VIC-20 loader
// Checks the reset state and keeps PRG writes below the BASIC RAM limit
`timescale 1ns/1ps
`default_nettype none

module vic_loader_assert (
	input wire                         clk_sys,
	input wire                         reset,
	input wire loader_pkg::mem_write_t mem_wr_i,
	input wire                         cart_reset_i,
	input wire [2:0]                   kind_i
);
	import loader_pkg::*;
	import vic_map_pkg::*;

	logic [2:0] kind_q;

	// The write port lags the address stage by one cycle
	always_ff @(posedge clk_sys) begin
		kind_q <= kind_i;
	end

	reset_state_a: assert property (@(posedge clk_sys)
		reset |=> !mem_wr_i.valid && !cart_reset_i)
		else $error("write strobe or cartridge reset set after a reset cycle");

	strobe_known_a: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown(mem_wr_i.valid))
		else $error("write strobe is unknown");

	// Pointer entries all sit in zero page, well below the limit
	prg_limit_a: assert property (@(posedge clk_sys) disable iff (reset)
		mem_wr_i.valid && kind_q == PRG |-> mem_wr_i.addr < prg_limit_c)
		else $error("PRG write at or above the BASIC RAM limit");

endmodule

bind vic_loader_top vic_loader_assert i_assert (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.mem_wr_i     (mem_wr_o),
	.cart_reset_i (cart_reset_o),
	.kind_i       (addr_wr.kind)
);

`default_nettype wire

// ==== bench/vic_loader_tb.sv ====
// Testbench for the VIC-20 loader
// Streams a table of downloads, models the expected memory writes and
// checks them in order and on time, along with the cartridge outputs
`timescale 1ns/1ps
`default_nettype none

module vic_loader_tb;
	import loader_pkg::*;
	import vic_map_pkg::*;

	typedef struct packed {
		file_kind_e  kind;
		logic [15:0] addr;
		logic [15:0] len;
		logic [7:0]  ext;
		cart_blk_t   mask;
	} row_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic [31:0] cyc;
	} exp_t;

	// Kind, header or start offset, data length, extension, block mask
	localparam int rows_n = 10;
	localparam row_t rows_c [rows_n] = '{
		'{PRG, 16'h1001, 16'd20, "P", 5'b00000},
		'{PRG, 16'h9FF4, 16'd20, "P", 5'b00000},
		'{ROM, 16'h3FFA, 16'd12, "R", 5'b00000},
		'{ROM, 16'h7FFA, 16'd12, "R", 5'b00000},
		'{CRT, 16'hA000, 16'd16, "C", 5'b10000},
		'{CRT, 16'hBFF8, 16'd16, "C", 5'b10000},
		'{CT,  16'h0000, 16'd16, "2", 5'b00010},
		'{CT,  16'h0000, 16'd12, "B", 5'b10000},
		'{CT,  16'h0000, 16'd12, "6", 5'b01000},
		'{CT,  16'h0000, 16'd8,  "9", 5'b00000}
	};

	localparam logic [15:0] ptr_addr_c [8] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030, 16'h0031, 16'h0032, 16'h00AE, 16'h00AF
	};

	logic        clk_sys;
	logic        reset;
	logic        dl_active;
	logic [7:0]  dl_index;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic [7:0]  dl_ext;
	logic        detach;
	cart_blk_t   extram_cfg;
	logic        cart_writable;
	mem_write_t  mem_wr;
	logic        cart_reset;
	cart_blk_t   ram_ext;
	cart_blk_t   ram_ext_ro;

	exp_t        exp_q [$];
	exp_t        head;
	logic [31:0] lcg_state;
	int          neg_cnt;
	int          cyc_cnt;
	int          timeout_limit;
	int          val_errors;
	int          miss_errors;
	int          extra_errors;
	int          state_errors;

	vic_loader_top i_dut (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.dl_active_i     (dl_active),
		.dl_index_i      (dl_index),
		.dl_wr_i         (dl_wr),
		.dl_addr_i       (dl_addr),
		.dl_data_i       (dl_data),
		.dl_ext_i        (dl_ext),
		.detach_i        (detach),
		.extram_cfg_i    (extram_cfg),
		.cart_writable_i (cart_writable),
		.mem_wr_o        (mem_wr),
		.cart_reset_o    (cart_reset),
		.ram_ext_o       (ram_ext),
		.ram_ext_ro_o    (ram_ext_ro)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Base address of a headerless cartridge from its extension
	function automatic logic [15:0] ext_base(input logic [7:0] ext);
		if (ext >= "2" && ext <= "9") begin
			return (16'(ext) - 16'h0030) * 16'h1000;
		end
		return (16'(ext) - 16'h0041 + 16'd10) * 16'h1000;
	endfunction

	function automatic logic [7:0] index_of(input file_kind_e kind);
		case (kind)
			PRG:     return 8'h01;
			ROM:     return 8'h06;
			CRT:     return 8'h41;
			default: return 8'h81;
		endcase
	endfunction

	task automatic expect_write(input logic [15:0] addr, input logic [7:0] data,
		input logic [31:0] cyc);
		exp_t e;
		e.addr = addr;
		e.data = data;
		e.cyc = cyc;
		exp_q.push_back(e);
	endtask

	task automatic strobe(input logic [24:0] offset, input logic [7:0] data);
		@(posedge clk_sys);
		dl_wr <= 1'b1;
		dl_addr <= offset;
		dl_data <= data;
	endtask

	task automatic check_value(input string what, input logic [7:0] got,
		input logic [7:0] want);
		if (got !== want) begin
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
			state_errors++;
		end
	endtask

	////////////////////
	// One download
	////////////////////

	task automatic run_row(input row_t row, input int r);
		logic [15:0] run;
		logic [15:0] limit;
		logic [24:0] offset;
		logic [7:0]  data;
		cart_blk_t   cfg;
		run = (row.kind == CT) ? ext_base(row.ext) : row.addr;
		limit = (row.kind == PRG) ? 16'hA000 : 16'hC000;
		lcg_state = lcg_next(lcg_state);
		cfg = lcg_state[4:0];
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_index <= index_of(row.kind);
		dl_ext <= row.ext;
		extram_cfg <= cfg;
		cart_writable <= r[0];
		repeat (2) @(posedge clk_sys);
		if (row.kind == PRG || row.kind == CRT) begin
			strobe(25'd0, row.addr[7:0]);
			strobe(25'd1, row.addr[15:8]);
		end
		for (int n = 0; n < row.len; n++) begin
			lcg_state = lcg_next(lcg_state);
			data = lcg_state[23:16];
			if (row.kind == ROM) begin
				offset = 25'(row.addr) + 25'(n);
			end else begin
				offset = (row.kind == CT) ? 25'(n) : 25'(n + 2);
			end
			strobe(offset, data);
			if (row.kind == ROM) begin
				if (offset >= 25'h4000 && offset < 25'h8000) begin
					expect_write(offset[15:0] + 16'h8000, data, neg_cnt + 4);
				end
			end else if (run < limit) begin
				expect_write(run, data, neg_cnt + 4);
				run = run + 16'd1;
			end
		end
		if (row.kind == CRT) begin
			@(negedge clk_sys);
			check_value("cart_reset_o during CRT", 8'(cart_reset), 8'h01);
		end
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		dl_active <= 1'b0;
		// Pointer bytes follow the end on alternate cycles
		if (row.kind == PRG) begin
			for (int i = 0; i < 8; i++) begin
				expect_write(ptr_addr_c[i], i[0] ? run[15:8] : run[7:0], neg_cnt + 4 + 2 * i);
			end
		end
		while (exp_q.size() != 0) begin
			@(posedge clk_sys);
		end
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("cart_reset_o after load", 8'(cart_reset), 8'h00);
		check_value("ram_ext_o", 8'(ram_ext), 8'(cfg | row.mask));
		check_value("ram_ext_ro_o", 8'(ram_ext_ro), r[0] ? 8'h00 : 8'(row.mask));
		@(posedge clk_sys);
		detach <= 1'b1;
		@(posedge clk_sys);
		detach <= 1'b0;
		@(negedge clk_sys);
		check_value("ram_ext_o after detach", 8'(ram_ext), 8'(cfg));
		check_value("ram_ext_ro_o after detach", 8'(ram_ext_ro), 8'h00);
	endtask

	// Detach while a CRT load still holds the machine in reset
	task automatic detach_during_crt();
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_index <= index_of(CRT);
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("cart_reset_o before detach", 8'(cart_reset), 8'h01);
		@(posedge clk_sys);
		detach <= 1'b1;
		@(posedge clk_sys);
		detach <= 1'b0;
		dl_active <= 1'b0;
		@(negedge clk_sys);
		check_value("cart_reset_o after detach", 8'(cart_reset), 8'h00);
	endtask

	////////////////////
	// Write monitor
	////////////////////

	always @(negedge clk_sys) begin
		neg_cnt = neg_cnt + 1;
		if (!reset) begin
			while (exp_q.size() > 0 && exp_q[0].cyc < neg_cnt) begin
				$display("Missing write to %h that was due at cycle %0d", exp_q[0].addr,
					exp_q[0].cyc);
				miss_errors++;
				void'(exp_q.pop_front());
			end
			if (mem_wr.valid) begin
				if (exp_q.size() == 0 || exp_q[0].cyc != neg_cnt) begin
					$display("Unexpected write of %h to %h at %0t", mem_wr.data, mem_wr.addr,
						$time);
					extra_errors++;
				end else begin
					head = exp_q.pop_front();
					if (mem_wr.addr !== head.addr || mem_wr.data !== head.data) begin
						$display("Error at %0t: write %h to %h, expected %h to %h", $time,
							mem_wr.data, mem_wr.addr, head.data, head.addr);
						val_errors++;
					end
				end
			end
		end
	end

	initial begin
		timeout_limit = 0;
		cyc_cnt = 0;
		for (int i = 0; i < rows_n; i++) begin
			timeout_limit += rows_c[i].len + 64;
		end
		while (cyc_cnt < timeout_limit) begin
			@(posedge clk_sys);
			cyc_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", timeout_limit);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		dl_active = 1'b0;
		dl_index = 8'h00;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = 8'h00;
		dl_ext = 8'h00;
		detach = 1'b0;
		extram_cfg = '0;
		cart_writable = 1'b0;
		lcg_state = 32'hd62efdd3;
		neg_cnt = 0;
		val_errors = 0;
		miss_errors = 0;
		extra_errors = 0;
		state_errors = 0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		for (int r = 0; r < rows_n; r++) begin
			run_row(rows_c[r], r);
		end
		detach_during_crt();
		repeat (8) @(posedge clk_sys);
		$display("Errors: value %0d, missing %0d, extra %0d, outputs %0d", val_errors,
			miss_errors, extra_errors, state_errors);
		if (val_errors + miss_errors + extra_errors + state_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/vic_map_pkg.sv
logic/loader_pkg.sv
logic/download_classifier.sv
logic/load_address_gen.sv
logic/basic_pointer_patcher.sv
logic/cart_block_tracker.sv
logic/vic_loader_top.sv
bench/vic_loader_assert.sv
bench/vic_loader_tb.sv
